/* design/d_cache_pkg.sv */
// cache geometry is fixed here; address widths must stay consistent with the tag/set/offset split
package d_cache_pkg;

  // ====================
  // geometry
  localparam int NUM_WAYS        = 4;
  localparam int WAY_WIDTH       = 2;
  localparam int NUM_SETS        = 16;
  localparam int SET_WIDTH       = 4;
  localparam int WORDS_IN_CL     = 4;
  localparam int WORD_WIDTH      = 32;
  localparam int OFFSET_WIDTH    = 4;   // byte offset inside a line
  localparam int WORD_OFF_WIDTH  = 2;   // word select, upper bits of the offset
  localparam int TAG_WIDTH       = 12;
  localparam int ID_WIDTH        = 3;

  // address is {tag, set, offset} from msb
  localparam int ADDR_WIDTH      = TAG_WIDTH + SET_WIDTH + OFFSET_WIDTH;
  localparam int LSB_SET         = OFFSET_WIDTH;
  localparam int LSB_TAG         = OFFSET_WIDTH + SET_WIDTH;

  // data array index is {set, way}
  localparam int DATA_ADDR_WIDTH = SET_WIDTH + WAY_WIDTH;
  localparam int NUM_LINES       = 1 << DATA_ADDR_WIDTH;

  // ====================
  // types
  typedef logic [WORDS_IN_CL-1:0][WORD_WIDTH-1:0] t_cl;  // word 0 in the low bits

  typedef enum logic [1:0] {
    RD_LU,
    WR_LU,
    FILL_LU
  } t_lu_op;

  typedef enum logic [1:0] {
    NO_RSP,
    HIT,
    MISS,
    FILL
  } t_lu_result;

  typedef enum logic {
    FILL_REQ_OP,
    DIRTY_EVICT_OP
  } t_fm_op;

endpackage

/* design/d_cache_ifs.sv */
// bundles only; stage timing is owned by the modules that drive them
`timescale 1ns/1ps

// state of one set as read in q2, or as written back
interface set_state_if;
  import d_cache_pkg::*;

  logic [NUM_WAYS-1:0]                valid;
  logic [NUM_WAYS-1:0]                modified;
  logic [NUM_WAYS-1:0]                mru;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;

  modport store (output valid, modified, mru, tags);
  modport user  (input  valid, modified, mru, tags);
endinterface

// one lookup as it moves down the pipe
interface lookup_if;
  import d_cache_pkg::*;

  logic                    valid;
  t_lu_op                  op;
  logic [TAG_WIDTH-1:0]    tag;
  logic [SET_WIDTH-1:0]    set;
  logic [OFFSET_WIDTH-1:0] offset;
  logic [ID_WIDTH-1:0]     id;
  logic [WORD_WIDTH-1:0]   word;           // write data
  t_cl                     cl_data;        // fill line
  logic                    fill_modified;  // fill carries dirty data

  modport src (output valid, op, tag, set, offset, id, word, cl_data, fill_modified);
  modport dst (input  valid, op, tag, set, offset, id, word, cl_data, fill_modified);
endinterface

/* design/tag_lookup.sv */
// set state is read at the q1 edge; a same-set write on that edge is forwarded, not lost
`timescale 1ns/1ps

module tag_lookup (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 lu_valid,
  input  d_cache_pkg::t_lu_op                  lu_op,
  input  logic [d_cache_pkg::ADDR_WIDTH-1:0]   lu_address,
  input  logic [d_cache_pkg::ID_WIDTH-1:0]     lu_id,
  input  logic [d_cache_pkg::WORD_WIDTH-1:0]   lu_word,
  input  d_cache_pkg::t_cl                     lu_cl_data,
  input  logic                                 lu_fill_modified,
  input  logic                                 set_wr_en,
  input  logic [d_cache_pkg::SET_WIDTH-1:0]    set_wr_set,
  set_state_if.user                            set_wr,
  lookup_if.src                                lu_q2,
  set_state_if.store                           state_q2
);
  import d_cache_pkg::*;

  logic [NUM_SETS-1:0][NUM_WAYS-1:0]  valid_q, modified_q, mru_q;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags_q [NUM_SETS];
  logic [SET_WIDTH-1:0]               set_q1;
  logic                               fwd_q1;

  assign set_q1 = lu_address[LSB_TAG-1:LSB_SET];
  assign fwd_q1 = set_wr_en && (set_wr_set == set_q1);  // q2 writes the set we read

  // ====================
  // tag / state array
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q    <= '0;
      modified_q <= '0;
      mru_q      <= '0;
    end else if (set_wr_en) begin
      valid_q[set_wr_set]    <= set_wr.valid;
      modified_q[set_wr_set] <= set_wr.modified;
      mru_q[set_wr_set]      <= set_wr.mru;
    end
  end

  always_ff @(posedge clk) begin
    if (set_wr_en)
      tags_q[set_wr_set] <= set_wr.tags;  // whole tag row of the written set
  end

  // registered set read with same-edge write bypass
  always_ff @(posedge clk) begin
    state_q2.valid    <= fwd_q1 ? set_wr.valid    : valid_q[set_q1];
    state_q2.modified <= fwd_q1 ? set_wr.modified : modified_q[set_q1];
    state_q2.mru      <= fwd_q1 ? set_wr.mru      : mru_q[set_q1];
    state_q2.tags     <= fwd_q1 ? set_wr.tags     : tags_q[set_q1];
  end

  // ====================
  // q1 -> q2 request
  always_ff @(posedge clk) begin
    if (reset)
      lu_q2.valid <= 1'b0;
    else
      lu_q2.valid <= lu_valid;
  end

  always_ff @(posedge clk) begin
    lu_q2.op            <= lu_op;
    lu_q2.tag           <= lu_address[ADDR_WIDTH-1:LSB_TAG];
    lu_q2.set           <= set_q1;
    lu_q2.offset        <= lu_address[OFFSET_WIDTH-1:0];
    lu_q2.id            <= lu_id;
    lu_q2.word          <= lu_word;
    lu_q2.cl_data       <= lu_cl_data;
    lu_q2.fill_modified <= lu_fill_modified && (lu_op == FILL_LU);
  end

  // set_update must leave at least one non-MRU way or the victim pick breaks
  a_mru_not_all: assert property (@(posedge clk) disable iff (reset)
    set_wr_en |=> !(&mru_q[$past(set_wr_set)]));

endmodule

/* design/hit_detect.sv */
// assumes a tag is present in at most one valid way of a set
`timescale 1ns/1ps

module hit_detect (
  lookup_if.dst                                 lu_q2,
  set_state_if.user                             state_q2,
  output logic [d_cache_pkg::NUM_WAYS-1:0]      hit_ways,
  output logic [d_cache_pkg::WAY_WIDTH-1:0]     hit_way
);
  import d_cache_pkg::*;

  // per-way compare, only for a live lookup
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_ways[w] = lu_q2.valid && state_q2.valid[w] && (state_q2.tags[w] == lu_q2.tag);
    end
  end

  // encode, zero when nothing hits
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_ways[w])
        hit_way = WAY_WIDTH'(w);
    end
  end

  // fills must never install a second copy of a tag
  always_comb begin
    assert final ($onehot0(hit_ways)) else $error("more than one way hit");
  end

endmodule

/* design/victim_select.sv */
// victim is the lowest invalid way, else the lowest non-MRU way; fills only
`timescale 1ns/1ps

module victim_select (
  lookup_if.dst                                 lu_q2,
  set_state_if.user                             state_q2,
  output logic [d_cache_pkg::NUM_WAYS-1:0]      victim_ways,
  output logic [d_cache_pkg::WAY_WIDTH-1:0]     victim_way,
  output logic                                  dirty_evict,
  output logic [d_cache_pkg::TAG_WIDTH-1:0]     victim_tag
);
  import d_cache_pkg::*;

  logic [WAY_WIDTH-1:0] free_way, lru_way;
  logic                 any_free, any_lru;

  assign any_free = ~&state_q2.valid;
  assign any_lru  = ~&state_q2.mru;

  // scan high to low so the lowest candidate wins
  always_comb begin
    free_way = '0;
    lru_way  = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!state_q2.valid[w])
        free_way = WAY_WIDTH'(w);
      if (!state_q2.mru[w])
        lru_way = WAY_WIDTH'(w);
    end
  end

  assign victim_way = any_free ? free_way : lru_way;

  always_comb begin
    victim_ways = '0;
    victim_ways[victim_way] = (lu_q2.op == FILL_LU) && (any_free || any_lru);
  end

  // old line must go out when it holds dirty data
  assign dirty_evict = |(state_q2.valid & state_q2.modified & victim_ways);
  assign victim_tag  = state_q2.tags[victim_way];

  always_comb begin
    if (lu_q2.valid && (lu_q2.op == FILL_LU))
      assert final ($onehot(victim_ways)) else $error("fill without a victim way");
  end

endmodule

/* design/set_update.sv */
// next set state is built in q2 and written back on the same edge that enters q3
`timescale 1ns/1ps

module set_update (
  input  logic                                  clk,
  input  logic                                  reset,
  lookup_if.dst                                 lu_q2,
  set_state_if.user                             state_q2,
  input  logic [d_cache_pkg::NUM_WAYS-1:0]      hit_ways,
  input  logic [d_cache_pkg::WAY_WIDTH-1:0]     hit_way,
  input  logic [d_cache_pkg::NUM_WAYS-1:0]      victim_ways,
  input  logic [d_cache_pkg::WAY_WIDTH-1:0]     victim_way,
  input  logic                                  dirty_evict,
  input  logic [d_cache_pkg::TAG_WIDTH-1:0]     victim_tag,
  output logic                                  set_wr_en,
  output logic [d_cache_pkg::SET_WIDTH-1:0]     set_wr_set,
  set_state_if.store                            set_wr,
  output logic [d_cache_pkg::DATA_ADDR_WIDTH-1:0] rd_addr,
  lookup_if.src                                 lu_q3,
  output logic                                  hit_q3,
  output logic [d_cache_pkg::DATA_ADDR_WIDTH-1:0] data_addr_q3,
  output logic                                  dirty_evict_q3,
  output logic [d_cache_pkg::TAG_WIDTH-1:0]     victim_tag_q3
);
  import d_cache_pkg::*;

  logic [NUM_WAYS-1:0]                new_valid, new_mod, new_mru;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] new_tags;
  logic                               is_fill;

  assign is_fill = (lu_q2.op == FILL_LU);

  // ====================
  // new set state
  always_comb begin
    new_valid = state_q2.valid;  // untouched ways keep their state
    new_mod   = state_q2.modified;
    new_mru   = state_q2.mru;
    new_tags  = state_q2.tags;
    if (!is_fill && (|hit_ways)) begin
      new_mru = new_mru | hit_ways;
      if (lu_q2.op == WR_LU)
        new_mod = new_mod | hit_ways;  // write hit dirties the way
    end
    if (is_fill) begin
      new_valid            = new_valid | victim_ways;
      new_mru              = new_mru | victim_ways;
      new_tags[victim_way] = lu_q2.tag;
      new_mod = lu_q2.fill_modified ? (new_mod | victim_ways) : (new_mod & ~victim_ways);
    end
    // all MRU: keep only the way just touched
    if (&new_mru)
      new_mru = is_fill ? victim_ways : hit_ways;
  end

  assign set_wr_en       = lu_q2.valid;
  assign set_wr_set      = lu_q2.set;
  assign set_wr.valid    = new_valid;
  assign set_wr.modified = new_mod;
  assign set_wr.mru      = new_mru;
  assign set_wr.tags     = new_tags;

  assign rd_addr = {lu_q2.set, (is_fill ? victim_way : hit_way)};  // data array index

  // ====================
  // q2 -> q3
  always_ff @(posedge clk) begin
    if (reset)
      lu_q3.valid <= 1'b0;
    else
      lu_q3.valid <= lu_q2.valid;
  end

  always_ff @(posedge clk) begin
    lu_q3.op            <= lu_q2.op;
    lu_q3.tag           <= lu_q2.tag;
    lu_q3.set           <= lu_q2.set;
    lu_q3.offset        <= lu_q2.offset;
    lu_q3.id            <= lu_q2.id;
    lu_q3.word          <= lu_q2.word;
    lu_q3.cl_data       <= lu_q2.cl_data;
    lu_q3.fill_modified <= lu_q2.fill_modified;
    hit_q3              <= |hit_ways;
    data_addr_q3        <= rd_addr;
    dirty_evict_q3      <= dirty_evict;
    victim_tag_q3       <= victim_tag;
  end

endmodule

/* design/data_store.sv */
// one read and one write per cycle; a write to the line being read is returned on the read
`timescale 1ns/1ps

module data_store (
  input  logic                                   clk,
  input  logic [d_cache_pkg::DATA_ADDR_WIDTH-1:0] rd_addr,
  input  logic                                   wr_en,
  input  logic [d_cache_pkg::DATA_ADDR_WIDTH-1:0] wr_addr,
  input  d_cache_pkg::t_cl                       wr_line,
  output d_cache_pkg::t_cl                       rd_line
);
  import d_cache_pkg::*;

  t_cl mem [NUM_LINES];
  t_cl rd_q;

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_line;
  end

  // synchronous read; the q3 write lands on this edge, so take it directly
  always_ff @(posedge clk) begin
    rd_q <= (wr_en && (wr_addr == rd_addr)) ? wr_line : mem[rd_addr];
  end

  assign rd_line = rd_q;

endmodule

/* design/lookup_response.sv */
// no back-pressure; the far-memory request is a one-cycle strobe that must be taken
`timescale 1ns/1ps

module lookup_response (
  lookup_if.dst                                  lu_q3,
  input  logic                                   hit_q3,
  input  logic [d_cache_pkg::DATA_ADDR_WIDTH-1:0] data_addr_q3,
  input  logic                                   dirty_evict_q3,
  input  logic [d_cache_pkg::TAG_WIDTH-1:0]      victim_tag_q3,
  input  d_cache_pkg::t_cl                       rd_line,
  output logic                                   rsp_valid,
  output d_cache_pkg::t_lu_op                    rsp_op,
  output d_cache_pkg::t_lu_result                rsp_result,
  output logic [d_cache_pkg::ID_WIDTH-1:0]       rsp_id,
  output logic [d_cache_pkg::ADDR_WIDTH-1:0]     rsp_address,
  output d_cache_pkg::t_cl                       rsp_cl_data,
  output logic                                   fm_req_valid,
  output d_cache_pkg::t_fm_op                    fm_req_op,
  output logic [d_cache_pkg::ADDR_WIDTH-1:0]     fm_req_address,
  output logic [d_cache_pkg::ID_WIDTH-1:0]       fm_req_id,
  output d_cache_pkg::t_cl                       fm_req_data,
  output logic                                   wr_en,
  output logic [d_cache_pkg::DATA_ADDR_WIDTH-1:0] wr_addr,
  output d_cache_pkg::t_cl                       wr_line
);
  import d_cache_pkg::*;

  logic                      is_fill, miss;
  logic [WORD_OFF_WIDTH-1:0] word_idx;
  t_cl                       merged;

  assign is_fill  = (lu_q3.op == FILL_LU);
  assign miss     = lu_q3.valid && !hit_q3 && !is_fill;  // rd or wr miss
  assign word_idx = lu_q3.offset[OFFSET_WIDTH-1 -: WORD_OFF_WIDTH];

  // ====================
  // response
  assign rsp_valid   = lu_q3.valid;
  assign rsp_op      = lu_q3.op;
  assign rsp_result  = !lu_q3.valid ? NO_RSP :
                       is_fill      ? FILL   :
                       hit_q3       ? HIT    : MISS;
  assign rsp_id      = lu_q3.id;
  assign rsp_address = {lu_q3.tag, lu_q3.set, lu_q3.offset};
  assign rsp_cl_data = is_fill                           ? lu_q3.cl_data :
                       ((lu_q3.op == RD_LU) && hit_q3)   ? rd_line       : '0;

  // ====================
  // data array write, word merge on write hit
  always_comb begin
    merged           = rd_line;
    merged[word_idx] = lu_q3.word;
  end

  assign wr_en   = lu_q3.valid && (is_fill || ((lu_q3.op == WR_LU) && hit_q3));
  assign wr_addr = data_addr_q3;
  assign wr_line = is_fill ? lu_q3.cl_data : merged;

  // far memory: fill request on miss, old line out on a dirty fill
  assign fm_req_valid   = miss || (lu_q3.valid && is_fill && dirty_evict_q3);
  assign fm_req_op      = miss ? FILL_REQ_OP : DIRTY_EVICT_OP;
  assign fm_req_address = miss ? rsp_address : {victim_tag_q3, lu_q3.set, {OFFSET_WIDTH{1'b0}}};
  assign fm_req_id      = lu_q3.id;
  assign fm_req_data    = miss ? '0 : rd_line;

endmodule

/* design/d_cache_top.sv */
// fixed 2-cycle lookup latency, one lookup per cycle, no stall path anywhere
`timescale 1ns/1ps

module d_cache_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                lu_valid,
  input  d_cache_pkg::t_lu_op                 lu_op,
  input  logic [d_cache_pkg::ADDR_WIDTH-1:0]  lu_address,
  input  logic [d_cache_pkg::ID_WIDTH-1:0]    lu_id,
  input  logic [d_cache_pkg::WORD_WIDTH-1:0]  lu_word,
  input  d_cache_pkg::t_cl                    lu_cl_data,
  input  logic                                lu_fill_modified,
  output logic                                rsp_valid,
  output d_cache_pkg::t_lu_op                 rsp_op,
  output d_cache_pkg::t_lu_result             rsp_result,
  output logic [d_cache_pkg::ID_WIDTH-1:0]    rsp_id,
  output logic [d_cache_pkg::ADDR_WIDTH-1:0]  rsp_address,
  output d_cache_pkg::t_cl                    rsp_cl_data,
  output logic                                fm_req_valid,
  output d_cache_pkg::t_fm_op                 fm_req_op,
  output logic [d_cache_pkg::ADDR_WIDTH-1:0]  fm_req_address,
  output logic [d_cache_pkg::ID_WIDTH-1:0]    fm_req_id,
  output d_cache_pkg::t_cl                    fm_req_data
);
  import d_cache_pkg::*;

  lookup_if    lu_q2 ();
  lookup_if    lu_q3 ();
  set_state_if state_q2 ();
  set_state_if set_wr ();

  logic [NUM_WAYS-1:0]        hit_ways, victim_ways;
  logic [WAY_WIDTH-1:0]       hit_way, victim_way;
  logic                       dirty_evict, dirty_evict_q3, hit_q3;
  logic [TAG_WIDTH-1:0]       victim_tag, victim_tag_q3;
  logic                       set_wr_en, wr_en;
  logic [SET_WIDTH-1:0]       set_wr_set;
  logic [DATA_ADDR_WIDTH-1:0] rd_addr, data_addr_q3, wr_addr;
  t_cl                        wr_line, rd_line;

  // ====================
  // q1 / q2
  tag_lookup u_tag_lookup (
    .clk, .reset, .lu_valid, .lu_op, .lu_address, .lu_id, .lu_word, .lu_cl_data,
    .lu_fill_modified, .set_wr_en, .set_wr_set, .set_wr(set_wr.user),
    .lu_q2(lu_q2.src), .state_q2(state_q2.store)
  );

  hit_detect u_hit_detect (
    .lu_q2(lu_q2.dst), .state_q2(state_q2.user), .hit_ways, .hit_way
  );

  victim_select u_victim_select (
    .lu_q2(lu_q2.dst), .state_q2(state_q2.user),
    .victim_ways, .victim_way, .dirty_evict, .victim_tag
  );

  set_update u_set_update (
    .clk, .reset, .lu_q2(lu_q2.dst), .state_q2(state_q2.user),
    .hit_ways, .hit_way, .victim_ways, .victim_way, .dirty_evict, .victim_tag,
    .set_wr_en, .set_wr_set, .set_wr(set_wr.store), .rd_addr, .lu_q3(lu_q3.src),
    .hit_q3, .data_addr_q3, .dirty_evict_q3, .victim_tag_q3
  );

  // ====================
  // q3
  data_store u_data_store (
    .clk, .rd_addr, .wr_en, .wr_addr, .wr_line, .rd_line
  );

  lookup_response u_lookup_response (
    .lu_q3(lu_q3.dst), .hit_q3, .data_addr_q3, .dirty_evict_q3, .victim_tag_q3, .rd_line,
    .rsp_valid, .rsp_op, .rsp_result, .rsp_id, .rsp_address, .rsp_cl_data,
    .fm_req_valid, .fm_req_op, .fm_req_address, .fm_req_id, .fm_req_data,
    .wr_en, .wr_addr, .wr_line
  );

endmodule

/* tb/cache_model.svh */
// in-order reference of tags, state and lines; assumes a fill never targets a tag already present
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// ====================
// model state per set and way
logic [NUM_WAYS-1:0]  m_valid [NUM_SETS];
logic [NUM_WAYS-1:0]  m_mod   [NUM_SETS];
logic [NUM_WAYS-1:0]  m_mru   [NUM_SETS];
logic [TAG_WIDTH-1:0] m_tag   [NUM_SETS][NUM_WAYS];
t_cl                  m_line  [NUM_SETS][NUM_WAYS];

task automatic model_reset();
  for (int s = 0; s < NUM_SETS; s++) begin
    m_valid[s] = '0;
    m_mod[s]   = '0;
    m_mru[s]   = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      m_tag[s][w]  = '0;
      m_line[s][w] = '0;
    end
  end
endtask

// mark a way most recent; once all ways are MRU only this one keeps the bit
task automatic touch_way(input logic [SET_WIDTH-1:0] s, input int w);
  m_mru[s][w] = 1'b1;
  if (&m_mru[s]) begin
    m_mru[s]    = '0;
    m_mru[s][w] = 1'b1;
  end
endtask

// ====================
// one lookup: update the state, return the expected data and far-memory fields
task automatic model_lookup(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [WORD_WIDTH-1:0] word, input t_cl line,
                            input logic fmod, output t_cl rsp_line,
                            output logic [ADDR_WIDTH-1:0] fm_addr, output t_cl fm_line);
  logic [TAG_WIDTH-1:0] tag;
  logic [SET_WIDTH-1:0] s;
  int                   hit;
  int                   free_w;
  int                   old_w;
  int                   v;
  tag      = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  s        = addr[OFFSET_WIDTH +: SET_WIDTH];
  hit      = -1;
  free_w   = -1;
  old_w    = -1;
  rsp_line = '0;
  fm_addr  = addr;  // a miss asks for its own line
  fm_line  = '0;
  for (int w = NUM_WAYS - 1; w >= 0; w--) begin
    if (m_valid[s][w] && (m_tag[s][w] == tag))
      hit = w;
    if (!m_valid[s][w])
      free_w = w;  // lowest invalid way
    if (!m_mru[s][w])
      old_w = w;   // lowest way not MRU
  end
  v = (free_w >= 0) ? free_w : old_w;
  if (op == FILL_LU) begin
    fm_addr       = {m_tag[s][v], s, OFFSET_WIDTH'(0)};  // old line address, used if dirty
    fm_line       = m_line[s][v];
    m_valid[s][v] = 1'b1;
    m_mod[s][v]   = fmod;
    m_tag[s][v]   = tag;
    m_line[s][v]  = line;
    rsp_line      = line;
    touch_way(s, v);
  end else if (hit >= 0) begin
    if (op == RD_LU)
      rsp_line = m_line[s][hit];
    else begin
      m_line[s][hit][addr[OFFSET_WIDTH-1 -: WORD_OFF_WIDTH]] = word;  // word merge
      m_mod[s][hit] = 1'b1;
    end
    touch_way(s, hit);
  end
endtask

`endif

/* tb/tb_d_cache.sv */
// lookups go back to back from a fixed table; each response is checked at the negedge after q3
`timescale 1ns/1ps

module tb_d_cache;
  import d_cache_pkg::*;

  `include "cache_model.svh"

  localparam int FM_NONE  = 0;  // expected far-memory request kind
  localparam int FM_FILL  = 1;
  localparam int FM_EVICT = 2;

  typedef struct {
    t_lu_op                op;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  fmod;
    t_lu_result            res;
    int                    fm;
  } row_t;

  typedef struct {
    int                    due;      // negedge count where the response shows
    logic [ID_WIDTH-1:0]   id;
    row_t                  row;
    t_cl                   line;
    logic [ADDR_WIDTH-1:0] fm_addr;
    t_cl                   fm_line;
  } exp_t;

  logic                  clk, reset, lu_valid, lu_fill_modified;
  t_lu_op                lu_op;
  logic [ADDR_WIDTH-1:0] lu_address;
  logic [ID_WIDTH-1:0]   lu_id;
  logic [WORD_WIDTH-1:0] lu_word;
  t_cl                   lu_cl_data;
  logic                  rsp_valid, fm_req_valid;
  t_lu_op                rsp_op;
  t_lu_result            rsp_result;
  logic [ID_WIDTH-1:0]   rsp_id, fm_req_id;
  logic [ADDR_WIDTH-1:0] rsp_address, fm_req_address;
  t_cl                   rsp_cl_data, fm_req_data;
  t_fm_op                fm_req_op;

  row_t        lookups[$];
  exp_t        exp_q[$];
  logic [31:0] rng_state;
  int          neg_count  = 0;
  int          checks     = 0;
  int          rsp_errors = 0;
  int          fm_errors  = 0;

  d_cache_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic add_lookup(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic fmod, input t_lu_result res, input int fm);
    lookups.push_back(row_t'{op, addr, fmod, res, fm});
  endtask

  // ====================
  // stimulus table with addresses as {tag, set, offset} in hex
  task automatic build_table();
    add_lookup(RD_LU,   20'h12330, 1'b0, MISS, FM_FILL);   // empty cache
    add_lookup(FILL_LU, 20'h12330, 1'b0, FILL, FM_NONE);
    add_lookup(RD_LU,   20'h12338, 1'b0, HIT,  FM_NONE);
    add_lookup(WR_LU,   20'h12334, 1'b0, HIT,  FM_NONE);   // write hit with a read right behind
    add_lookup(RD_LU,   20'h12330, 1'b0, HIT,  FM_NONE);
    add_lookup(FILL_LU, 20'hA0150, 1'b1, FILL, FM_NONE);   // set 5 ways 0..3 in order
    add_lookup(FILL_LU, 20'hA0250, 1'b0, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'hA0350, 1'b0, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'hA0450, 1'b1, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'hA0550, 1'b0, FILL, FM_EVICT);  // way 0 went out filled modified
    add_lookup(FILL_LU, 20'hA0650, 1'b0, FILL, FM_NONE);   // clean way 1
    add_lookup(RD_LU,   20'hA0350, 1'b0, HIT,  FM_NONE);   // all MRU so only way 2 stays MRU
    add_lookup(FILL_LU, 20'hA0750, 1'b0, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'hA0850, 1'b0, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'hA0950, 1'b0, FILL, FM_EVICT);  // way 3
    add_lookup(FILL_LU, 20'h45630, 1'b0, FILL, FM_NONE);   // set 3 fills up
    add_lookup(FILL_LU, 20'h45730, 1'b0, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'h45830, 1'b0, FILL, FM_NONE);
    add_lookup(FILL_LU, 20'h45930, 1'b0, FILL, FM_EVICT);  // written line leaves merged
    add_lookup(WR_LU,   20'hBEE7C, 1'b0, MISS, FM_FILL);   // write miss allocates nothing
    add_lookup(RD_LU,   20'hBEE70, 1'b0, MISS, FM_FILL);
    add_lookup(FILL_LU, 20'hBEE70, 1'b0, FILL, FM_NONE);
    add_lookup(WR_LU,   20'hBEE78, 1'b0, HIT,  FM_NONE);   // both forwarding paths
    add_lookup(RD_LU,   20'hBEE74, 1'b0, HIT,  FM_NONE);
  endtask

  task automatic apply_lookup(input int i);
    exp_t                  e;
    logic [WORD_WIDTH-1:0] word;
    t_cl                   line;
    word = next_random();
    for (int k = 0; k < WORDS_IN_CL; k++)
      line[k] = next_random();
    e.due = neg_count + 3;  // q2 and q3 edges plus the following negedge
    e.id  = ID_WIDTH'(i);
    e.row = lookups[i];
    model_lookup(e.row.op, e.row.addr, word, line, e.row.fmod, e.line, e.fm_addr, e.fm_line);
    exp_q.push_back(e);
    lu_valid         <= 1'b1;
    lu_op            <= e.row.op;
    lu_address       <= e.row.addr;
    lu_id            <= e.id;
    lu_word          <= word;
    lu_cl_data       <= line;
    lu_fill_modified <= e.row.fmod;
  endtask

  // ====================
  // checks
  task automatic check_response(input exp_t e);
    logic   fm_exp;
    t_fm_op op_exp;
    fm_exp = (e.row.fm != FM_NONE);
    op_exp = (e.row.fm == FM_EVICT) ? DIRTY_EVICT_OP : FILL_REQ_OP;
    checks++;
    assert (rsp_valid === 1'b1 && rsp_id === e.id && rsp_op === e.row.op &&
            rsp_address === e.row.addr && rsp_result === e.row.res) else begin
      rsp_errors++;
      $display("** Error at %0t: lookup %0d got valid %b id %0d addr %h result %s, want %s",
               $time, e.id, rsp_valid, rsp_id, rsp_address, rsp_result.name(), e.row.res.name());
    end
    assert (rsp_cl_data === e.line) else begin
      rsp_errors++;
      $display("** Error at %0t: lookup %0d line %h, want %h", $time, e.id, rsp_cl_data, e.line);
    end
    assert (fm_req_valid === fm_exp) else begin
      fm_errors++;
      $display("** Error at %0t: lookup %0d far-memory valid %b, want %b",
               $time, e.id, fm_req_valid, fm_exp);
    end
    if (fm_exp) begin
      assert (fm_req_op === op_exp && fm_req_address === e.fm_addr &&
              fm_req_id === e.id && fm_req_data === e.fm_line) else begin
        fm_errors++;
        $display("** Error at %0t: lookup %0d far-memory %s addr %h data %h, want %s %h %h",
                 $time, e.id, fm_req_op.name(), fm_req_address, fm_req_data,
                 op_exp.name(), e.fm_addr, e.fm_line);
      end
    end
  endtask

  always @(negedge clk) begin
    neg_count++;
    if (neg_count > lookups.size() + 20) begin
      $display("timeout: %0d responses never arrived", exp_q.size());
      $display("FAIL: see errors above");
      $finish;
    end else if (exp_q.size() != 0 && exp_q[0].due == neg_count) begin
      check_response(exp_q.pop_front());
    end else if (!reset) begin
      assert (rsp_valid === 1'b0 && fm_req_valid === 1'b0) else begin
        rsp_errors++;
        $display("** Error at %0t: strobe with no lookup due", $time);
      end
    end
  end

  // ====================
  // main sequence
  initial begin
    reset            = 1'b1;
    lu_valid         = 1'b0;
    lu_op            = RD_LU;
    lu_address       = '0;
    lu_id            = '0;
    lu_word          = '0;
    lu_cl_data       = '0;
    lu_fill_modified = 1'b0;
    rng_state        = 32'd60465;
    model_reset();
    build_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    foreach (lookups[i]) begin
      @(posedge clk);
      apply_lookup(i);
    end
    @(posedge clk);
    lu_valid <= 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);  // one more idle cycle gets checked
    $display("checks: %0d, response errors: %0d, far-memory errors: %0d",
             checks, rsp_errors, fm_errors);
    if (rsp_errors + fm_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* d_cache_top.f */
+incdir+tb
design/d_cache_pkg.sv
design/d_cache_ifs.sv
design/tag_lookup.sv
design/hit_detect.sv
design/victim_select.sv
design/set_update.sv
design/data_store.sv
design/lookup_response.sv
design/d_cache_top.sv
tb/tb_d_cache.sv

/* Makefile */
TOP := tb_d_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): d_cache_top.f $(wildcard design/*.sv) tb/tb_d_cache.sv tb/cache_model.svh
	verilator --binary --assert -j 0 --top-module $(TOP) -f d_cache_top.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only -Wall --timing --top-module d_cache_top -f d_cache_top.f

clean:
	rm -rf obj_dir
